/* filelist.f */
hw/mips_pkg.sv
hw/pc_unit.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/mem_access.sv
hw/mips_core.sv
tb/tb_mem_model.sv
tb/tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_mips_core
RTL_TOP   ?= mips_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# pass only if the exact pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;

	localparam int clk_period   = 20;
	localparam int reset_cycles = 5;

	logic        clk;
	logic        rst_n;
	logic [31:0] ir_addr;
	logic [31:0] ir;
	logic [31:0] read_data_mem;
	logic        cen;
	logic        wen;
	logic        oen;
	logic [6:0]  a;
	logic [31:0] data_to_mem;

	// one entry per executed instruction with strobes packed as {cen, wen, oen}
	logic [31:0] exp_pc [256];
	logic [2:0]  exp_strobe [256];
	logic [6:0]  exp_a [256];
	logic [31:0] exp_d [256];
	logic [7:0]  n_trace;
	logic [7:0]  cyc;
	logic        checking;
	logic        prog_ready;

	// register and memory contents the program should produce
	logic [31:0] regs [32];
	logic [31:0] dmem [128];
	logic [31:0] cur_pc;
	int          next_slot;

	mips_core UUT (
		.clk(clk), .rst_n(rst_n), .ir_addr(ir_addr), .ir(ir),
		.read_data_mem(read_data_mem), .cen(cen), .wen(wen), .oen(oen),
		.a(a), .data_to_mem(data_to_mem)
	);

	tb_mem_model u_mem (
		.clk(clk), .ir_addr(ir_addr), .ir(ir), .cen(cen), .wen(wen), .oen(oen),
		.a(a), .data_to_mem(data_to_mem), .read_data_mem(read_data_mem)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		if (!rst_n) begin
			cyc <= 8'd0;
		end else begin
			cyc <= cyc + 8'd1;
		end
	end

	assign checking = rst_n && (cyc < n_trace);

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	task automatic expect_cycle(input logic [31:0] pc, input logic [2:0] strobe,
		input logic [6:0] wa, input logic [31:0] wd);
		exp_pc[n_trace]     = pc;
		exp_strobe[n_trace] = strobe;
		exp_a[n_trace]      = wa;
		exp_d[n_trace]      = wd;
		n_trace             = n_trace + 8'd1;
	endtask

	// word at cur_pc that is expected to run there
	task automatic emit(input logic [31:0] w, input logic [2:0] strobe,
		input logic [6:0] wa, input logic [31:0] wd);
		u_mem.prog[cur_pc[8:2]] = w;
		expect_cycle(cur_pc, strobe, wa, wd);
		cur_pc = cur_pc + 32'd4;
	endtask

	// addi $1, $0, 0xdead that a taken branch or jump must skip
	task automatic place_dead_word();
		u_mem.prog[cur_pc[8:2]] = 32'h2001_dead;
		cur_pc = cur_pc + 32'd4;
	endtask

	task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
		if (idx != 5'd0) begin
			regs[idx] = val;
		end
	endtask

	// addi rt, $0, imm
	task automatic load_imm(input logic [4:0] rt, input logic [15:0] imm);
		emit({6'h08, 5'd0, rt, imm}, 3'b111, 7'd0, 32'd0);
		set_reg(rt, sext16(imm));
	endtask

	task automatic do_rtype(input logic [5:0] fn, input logic [4:0] rd, rs, rt, sh);
		logic [31:0] r;
		case (fn)
			6'h22: r = regs[rs] - regs[rt];
			6'h24: r = regs[rs] & regs[rt];
			6'h25: r = regs[rs] | regs[rt];
			6'h2a: r = {31'd0, $signed(regs[rs]) < $signed(regs[rt])};
			6'h00: r = regs[rt] << sh;
			6'h02: r = regs[rt] >> sh;
			default: r = regs[rs] + regs[rt];
		endcase
		emit({6'h00, rs, rt, rd, sh, fn}, 3'b111, 7'd0, 32'd0);
		set_reg(rd, r);
	endtask

	// sw or lw with a base register and signed byte offset
	task automatic mem_op(input logic is_store, input logic [4:0] rt, base,
		input logic [15:0] off);
		logic [31:0] byte_addr;
		logic [6:0]  idx;
		byte_addr = regs[base] + sext16(off);
		idx       = byte_addr[8:2];
		if (is_store) begin
			emit({6'h2b, base, rt, off}, 3'b001, idx, regs[rt]);
			dmem[idx] = regs[rt];
		end else begin
			emit({6'h23, base, rt, off}, 3'b010, idx, 32'd0);
			set_reg(rt, dmem[idx]);
		end
	endtask

	task automatic store_new(input logic [4:0] rt);
		mem_op(1'b1, rt, 5'd0, 16'(next_slot * 4));
		next_slot++;
	endtask

	task automatic branch(input logic is_bne, input logic [4:0] rs, rt);
		logic taken;
		taken = (regs[rs] != regs[rt]) == is_bne;
		if (taken) begin
			emit({5'b00010, is_bne, rs, rt, 16'd2}, 3'b111, 7'd0, 32'd0);
			place_dead_word();
			place_dead_word();
		end else begin
			// target is never reached, so any forward offset will do
			emit({5'b00010, is_bne, rs, rt, 16'(1 + $urandom_range(5))},
				3'b111, 7'd0, 32'd0);
		end
	endtask

	task automatic jump_over();
		logic [31:0] target;
		target = cur_pc + 32'd12;
		emit({6'h02, target[27:2]}, 3'b111, 7'd0, 32'd0);
		place_dead_word();
		place_dead_word();
	endtask

	// jal to a routine that stores $31 and returns with jr
	task automatic call_and_return();
		logic [31:0] p;
		logic [31:0] sub_addr;
		logic [31:0] cont_addr;
		p         = cur_pc;
		sub_addr  = p + 32'd8;
		cont_addr = p + 32'd16;
		emit({6'h03, sub_addr[27:2]}, 3'b111, 7'd0, 32'd0);
		set_reg(5'd31, cur_pc);
		// return slot jumps over the routine
		u_mem.prog[cur_pc[8:2]] = {6'h02, cont_addr[27:2]};
		cur_pc = sub_addr;
		store_new(5'd31);
		emit({6'h00, 5'd31, 15'd0, 6'h08}, 3'b111, 7'd0, 32'd0);
		expect_cycle(p + 32'd4, 3'b111, 7'd0, 32'd0);
	endtask

	task automatic assemble_program();
		logic [15:0] same;
		for (int i = 0; i < 128; i++) begin
			u_mem.prog[i[6:0]] = 32'd0;
		end
		for (int i = 0; i < 32; i++) begin
			regs[i[4:0]] = 32'd0;
		end
		cur_pc    = 32'd0;
		n_trace   = 8'd0;
		next_slot = 0;
		// no-ops first
		emit(32'd0, 3'b111, 7'd0, 32'd0);
		emit(32'd0, 3'b111, 7'd0, 32'd0);
		repeat (2) begin
			load_imm(5'd2, 16'($urandom()));
			load_imm(5'd3, 16'($urandom()));
			// add, sub, and, or, then slt both ways round
			do_rtype(6'h20, 5'd6, 5'd2, 5'd3, 5'd0);
			store_new(5'd6);
			do_rtype(6'h22, 5'd7, 5'd2, 5'd3, 5'd0);
			store_new(5'd7);
			do_rtype(6'h24, 5'd8, 5'd2, 5'd3, 5'd0);
			store_new(5'd8);
			do_rtype(6'h25, 5'd9, 5'd2, 5'd3, 5'd0);
			store_new(5'd9);
			do_rtype(6'h2a, 5'd10, 5'd2, 5'd3, 5'd0);
			store_new(5'd10);
			do_rtype(6'h2a, 5'd11, 5'd3, 5'd2, 5'd0);
			store_new(5'd11);
			// sll then srl
			do_rtype(6'h00, 5'd12, 5'd0, 5'd2, 5'($urandom_range(31)));
			store_new(5'd12);
			do_rtype(6'h02, 5'd13, 5'd0, 5'd3, 5'($urandom_range(31)));
			store_new(5'd13);
		end
		// round trip reloaded through a based address
		store_new(5'd6);
		load_imm(5'd20, 16'(next_slot * 4 + 4));
		mem_op(1'b0, 5'd14, 5'd20, 16'hfff8);
		store_new(5'd14);
		// $zero ignores both writes
		load_imm(5'd0, 16'($urandom()));
		do_rtype(6'h20, 5'd0, 5'd2, 5'd3, 5'd0);
		store_new(5'd0);
		same = regs[2][15:0];
		load_imm(5'd4, same);
		load_imm(5'd5, same ^ 16'h0001);
		branch(1'b0, 5'd2, 5'd4);
		branch(1'b0, 5'd2, 5'd5);
		branch(1'b1, 5'd2, 5'd5);
		branch(1'b1, 5'd2, 5'd4);
		jump_over();
		call_and_return();
		// jump to itself is expected on two cycles
		u_mem.prog[cur_pc[8:2]] = {6'h02, cur_pc[27:2]};
		expect_cycle(cur_pc, 3'b111, 7'd0, 32'd0);
		expect_cycle(cur_pc, 3'b111, 7'd0, 32'd0);
	endtask

	reset_idle: assert property (@(posedge clk)
		!rst_n |-> (ir_addr == 32'd0) && cen && wen && oen
	) else begin
		$display("FAILED reset state ir_addr %h {cen,wen,oen} %h",
			$sampled(ir_addr), $sampled({cen, wen, oen}));
		abort_run();
	end

	pc_follows_program: assert property (@(posedge clk)
		checking |-> ir_addr == exp_pc[cyc]
	) else begin
		$display("FAILED ir_addr got %h expected %h",
			$sampled(ir_addr), exp_pc[$sampled(cyc)]);
		abort_run();
	end

	strobes_match: assert property (@(posedge clk)
		checking |-> {cen, wen, oen} == exp_strobe[cyc]
	) else begin
		$display("FAILED {cen,wen,oen} got %h expected %h",
			$sampled({cen, wen, oen}), exp_strobe[$sampled(cyc)]);
		abort_run();
	end

	addr_match: assert property (@(posedge clk)
		checking && exp_strobe[cyc] != 3'b111 |-> a == exp_a[cyc]
	) else begin
		$display("FAILED a got %h expected %h", $sampled(a), exp_a[$sampled(cyc)]);
		abort_run();
	end

	store_data_match: assert property (@(posedge clk)
		checking && exp_strobe[cyc] == 3'b001 |-> data_to_mem == exp_d[cyc]
	) else begin
		$display("FAILED data_to_mem got %h expected %h",
			$sampled(data_to_mem), exp_d[$sampled(cyc)]);
		abort_run();
	end

	initial begin
		rst_n      = 1'b0;
		prog_ready = 1'b0;
		void'($urandom(54697));
		assemble_program();
		// a store word waits at address 0 while reset is held
		u_mem.prog[0] = {6'h2b, 5'd0, 5'd0, 16'd0};
		prog_ready = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		// the first cycle after reset runs a no-op
		u_mem.prog[0] = 32'd0;
		rst_n = 1'b1;
		wait (cyc == n_trace);
		@(negedge clk);
		if (ir_addr == exp_pc[n_trace - 8'd1]) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("FAILED ir_addr after last instruction got %h expected %h",
				ir_addr, exp_pc[n_trace - 8'd1]);
			abort_run();
		end
	end

	// twice the expected run length
	initial begin
		wait (prog_ready);
		#(2 * (int'(n_trace) + reset_cycles) * clk_period);
		$display("timeout, the program did not reach its last instruction");
		abort_run();
	end

endmodule

`default_nettype wire

/* tb/tb_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
	input  logic        clk,
	input  logic [31:0] ir_addr,
	output logic [31:0] ir,
	input  logic        cen,
	input  logic        wen,
	input  logic        oen,
	input  logic [6:0]  a,
	input  logic [31:0] data_to_mem,
	output logic [31:0] read_data_mem
);

	// program words are placed by the testbench before reset ends
	logic [31:0] prog [128];
	logic [31:0] data [128];

	// every word differs, so a wrong address shows up
	initial begin
		for (int i = 0; i < 128; i++) begin
			data[i[6:0]] = 32'hfeed_0000 ^ (32'(i) * 32'h0001_0001);
		end
	end

	// fetch ignores the byte offset bits
	assign ir = prog[ir_addr[8:2]];

	assign read_data_mem = (!cen && !oen) ? data[a] : 32'd0;

	always @(posedge clk) begin
		if (!cen && !wen) begin
			data[a] <= data_to_mem;
		end
	end

endmodule

`default_nettype wire

/* hw/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_core
	import mips_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	output logic [xlen-1:0]         ir_addr,
	input  logic [xlen-1:0]         ir,
	input  logic [xlen-1:0]         read_data_mem,
	output logic                    cen,
	output logic                    wen,
	output logic                    oen,
	output logic [mem_addr_w-1:0]   a,
	output logic [xlen-1:0]         data_to_mem
);

	// decoder outputs
	logic [reg_addr_w-1:0] rs_idx;
	logic [reg_addr_w-1:0] rt_idx;
	logic [reg_addr_w-1:0] dest_reg;
	logic [shamt_w-1:0]    shamt;
	logic [imm_w-1:0]      imm;
	logic [jaddr_w-1:0]    jump_addr;
	alu_op_e               alu_op;
	logic                  alu_src_imm;
	logic                  reg_write;
	wb_sel_e               wb_sel;
	logic                  mem_read;
	logic                  mem_write;
	next_pc_e              next_pc_kind;

	// datapath
	logic [xlen-1:0] rs_data;
	logic [xlen-1:0] rt_data;
	logic [xlen-1:0] alu_result;
	logic            zero;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] wb_data;

	pc_unit u_pc_unit (
		.clk(clk), .rst_n(rst_n), .next_pc_kind(next_pc_kind), .imm(imm),
		.jump_addr(jump_addr), .rs_data(rs_data), .zero(zero),
		.ir_addr(ir_addr), .pc_plus4(pc_plus4)
	);

	instr_decoder u_instr_decoder (
		.ir(ir), .rs_idx(rs_idx), .rt_idx(rt_idx), .dest_reg(dest_reg),
		.shamt(shamt), .imm(imm), .jump_addr(jump_addr), .alu_op(alu_op),
		.alu_src_imm(alu_src_imm), .reg_write(reg_write), .wb_sel(wb_sel),
		.mem_read(mem_read), .mem_write(mem_write), .next_pc_kind(next_pc_kind)
	);

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .rs_idx(rs_idx), .rt_idx(rt_idx),
		.wr_idx(dest_reg), .wr_en(reg_write), .wr_data(wb_data),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	alu u_alu (
		.alu_op(alu_op), .rs_data(rs_data), .rt_data(rt_data), .imm(imm),
		.alu_src_imm(alu_src_imm), .shamt(shamt),
		.alu_result(alu_result), .zero(zero)
	);

	mem_access u_mem_access (
		.rst_n(rst_n), .mem_read(mem_read), .mem_write(mem_write),
		.alu_result(alu_result), .rt_data(rt_data), .wb_sel(wb_sel),
		.pc_plus4(pc_plus4), .read_data_mem(read_data_mem),
		.cen(cen), .wen(wen), .oen(oen), .a(a),
		.data_to_mem(data_to_mem), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

/* hw/mem_access.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_access
	import mips_pkg::*;
(
	input  logic                    rst_n,
	input  logic                    mem_read,
	input  logic                    mem_write,
	input  logic [xlen-1:0]         alu_result,
	input  logic [xlen-1:0]         rt_data,
	input  wb_sel_e                 wb_sel,
	input  logic [xlen-1:0]         pc_plus4,
	input  logic [xlen-1:0]         read_data_mem,
	output logic                    cen,
	output logic                    wen,
	output logic                    oen,
	output logic [mem_addr_w-1:0]   a,
	output logic [xlen-1:0]         data_to_mem,
	output logic [xlen-1:0]         wb_data
);

	logic [xlen-1:0] word_addr;

	// byte address to word index
	assign word_addr = alu_result >> 2;
	assign a         = word_addr[mem_addr_w-1:0];

	// active-low strobes, held idle during reset
	assign cen = !rst_n || !(mem_read || mem_write);
	assign wen = !rst_n || !mem_write;
	assign oen = !rst_n || !mem_read;

	assign data_to_mem = rt_data;

	always_comb begin
		case (wb_sel)
			wb_mem:  wb_data = read_data_mem;
			wb_link: wb_data = pc_plus4;
			default: wb_data = alu_result;
		endcase
	end

	// a write strobe needs the chip enable, and never overlaps a read
	always_comb begin
		if (!wen) begin
			assert (!cen && oen)
			else $error("wen low with cen=%b oen=%b", cen, oen);
		end
	end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu
	import mips_pkg::*;
(
	input  alu_op_e              alu_op,
	input  logic [xlen-1:0]      rs_data,
	input  logic [xlen-1:0]      rt_data,
	input  logic [imm_w-1:0]     imm,
	input  logic                 alu_src_imm,
	input  logic [shamt_w-1:0]   shamt,
	output logic [xlen-1:0]      alu_result,
	output logic                 zero
);

	logic [xlen-1:0] imm_sext;
	logic [xlen-1:0] operand_b;

	assign imm_sext  = {{(xlen-imm_w){imm[imm_w-1]}}, imm};
	assign operand_b = alu_src_imm ? imm_sext : rt_data;

	always_comb begin
		case (alu_op)
			alu_add: begin
				alu_result = rs_data + operand_b;
			end
			alu_sub: begin
				alu_result = rs_data - operand_b;
			end
			alu_and: begin
				alu_result = rs_data & operand_b;
			end
			alu_or: begin
				alu_result = rs_data | operand_b;
			end
			alu_slt: begin
				// signed compare
				alu_result = {{(xlen-1){1'b0}}, $signed(rs_data) < $signed(operand_b)};
			end
			// shifts act on rt, never on rs
			alu_sll: begin
				alu_result = rt_data << shamt;
			end
			alu_srl: begin
				alu_result = rt_data >> shamt;
			end
			default: begin
				alu_result = '0;
			end
		endcase
	end

	// beq/bne look at this after a subtract
	assign zero = (alu_result == '0);

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file
	import mips_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [reg_addr_w-1:0]  rs_idx,
	input  logic [reg_addr_w-1:0]  rt_idx,
	input  logic [reg_addr_w-1:0]  wr_idx,
	input  logic                   wr_en,
	input  logic [xlen-1:0]        wr_data,
	output logic [xlen-1:0]        rs_data,
	output logic [xlen-1:0]        rt_data
);

	logic [xlen-1:0] regs [2**reg_addr_w];

	// $zero is never written, so it stays at its reset value
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// combinational reads, no bypass needed
	assign rs_data = regs[rs_idx];
	assign rt_data = regs[rt_idx];

	zero_reg_reads_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		((rs_idx == '0) -> (rs_data == '0)) &&
		((rt_idx == '0) -> (rt_data == '0))
	) else $error("register 0 read back nonzero");

endmodule

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
	import mips_pkg::*;
(
	input  logic [xlen-1:0]        ir,
	output logic [reg_addr_w-1:0]  rs_idx,
	output logic [reg_addr_w-1:0]  rt_idx,
	output logic [reg_addr_w-1:0]  dest_reg,
	output logic [shamt_w-1:0]     shamt,
	output logic [imm_w-1:0]       imm,
	output logic [jaddr_w-1:0]     jump_addr,
	output alu_op_e                alu_op,
	output logic                   alu_src_imm,
	output logic                   reg_write,
	output wb_sel_e                wb_sel,
	output logic                   mem_read,
	output logic                   mem_write,
	output next_pc_e               next_pc_kind
);

	opcode_e               opcode;
	funct_e                funct;
	logic [reg_addr_w-1:0] rd_idx;

	// fixed field positions
	assign opcode    = opcode_e'(ir[op_lsb +: 6]);
	assign funct     = funct_e'(ir[0 +: funct_w]);
	assign rs_idx    = ir[rs_lsb +: reg_addr_w];
	assign rt_idx    = ir[rt_lsb +: reg_addr_w];
	assign rd_idx    = ir[rd_lsb +: reg_addr_w];
	assign shamt     = ir[shamt_lsb +: shamt_w];
	assign imm       = ir[0 +: imm_w];
	assign jump_addr = ir[0 +: jaddr_w];

	always_comb begin
		// no-op unless a known code says otherwise
		alu_op       = alu_add;
		alu_src_imm  = 1'b0;
		reg_write    = 1'b0;
		wb_sel       = wb_alu;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		next_pc_kind = pc_seq;
		dest_reg     = rd_idx;

		// all-zero word would otherwise decode as sll $0
		if (ir != '0) begin
			case (opcode)
				op_rtype: begin
					reg_write = 1'b1;
					case (funct)
						fn_sll: alu_op = alu_sll;
						fn_srl: alu_op = alu_srl;
						fn_add: alu_op = alu_add;
						fn_sub: alu_op = alu_sub;
						fn_and: alu_op = alu_and;
						fn_or:  alu_op = alu_or;
						fn_slt: alu_op = alu_slt;
						fn_jr: begin
							reg_write    = 1'b0;
							next_pc_kind = pc_jreg;
						end
						default: reg_write = 1'b0;
					endcase
				end
				op_addi: begin
					alu_src_imm = 1'b1;
					reg_write   = 1'b1;
					dest_reg    = rt_idx;
				end
				op_lw: begin
					alu_src_imm = 1'b1;
					reg_write   = 1'b1;
					wb_sel      = wb_mem;
					mem_read    = 1'b1;
					dest_reg    = rt_idx;
				end
				op_sw: begin
					alu_src_imm = 1'b1;
					mem_write   = 1'b1;
				end
				op_beq: begin
					alu_op       = alu_sub;
					next_pc_kind = pc_beq;
				end
				op_bne: begin
					alu_op       = alu_sub;
					next_pc_kind = pc_bne;
				end
				op_j: next_pc_kind = pc_jump;
				op_jal: begin
					next_pc_kind = pc_jump;
					reg_write    = 1'b1;
					wb_sel       = wb_link;
					dest_reg     = ra_reg;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/pc_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module pc_unit
	import mips_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  next_pc_e            next_pc_kind,
	input  logic [imm_w-1:0]    imm,
	input  logic [jaddr_w-1:0]  jump_addr,
	input  logic [xlen-1:0]     rs_data,
	input  logic                zero,
	output logic [xlen-1:0]     ir_addr,
	output logic [xlen-1:0]     pc_plus4
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] branch_target;
	logic [xlen-1:0] jump_target;
	logic [xlen-1:0] pc_next;

	assign pc_plus4 = pc + pc_step;

	// word offset from the delay slot address
	assign branch_target = pc_plus4 + {{(xlen-imm_w-2){imm[imm_w-1]}}, imm, 2'b00};

	// pseudo-direct jump keeps the current region
	assign jump_target = {pc[xlen-1:xlen-4], jump_addr, 2'b00};

	always_comb begin
		case (next_pc_kind)
			pc_beq: begin
				pc_next = zero ? branch_target : pc_plus4;
			end
			pc_bne: begin
				pc_next = zero ? pc_plus4 : branch_target;
			end
			pc_jump: begin
				pc_next = jump_target;
			end
			pc_jreg: begin
				pc_next = rs_data;
			end
			default: begin
				pc_next = pc_plus4;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	assign ir_addr = pc;

	// a jr through a misaligned register would break this
	ir_addr_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		ir_addr[1:0] == 2'b00
	) else $error("ir_addr not word aligned: %h", ir_addr);

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// datapath and address widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam int mem_addr_w = 7;
	localparam int shamt_w    = 5;
	localparam int imm_w      = 16;
	localparam int jaddr_w    = 26;

	localparam logic [xlen-1:0]       pc_step = 32'd4;
	localparam logic [reg_addr_w-1:0] ra_reg  = 5'd31;

	// low bit of each instruction field
	localparam int op_lsb    = 26;
	localparam int rs_lsb    = 21;
	localparam int rt_lsb    = 16;
	localparam int rd_lsb    = 11;
	localparam int shamt_lsb = 6;
	localparam int funct_w   = 6;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// r-type function field
	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_srl = 6'h02,
		fn_jr  = 6'h08,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_sll,
		alu_srl
	} alu_op_e;

	// write-back source
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_link
	} wb_sel_e;

	typedef enum logic [2:0] {
		pc_seq,
		pc_beq,
		pc_bne,
		pc_jump,
		pc_jreg
	} next_pc_e;

endpackage

`default_nettype wire
